/* bst_insert.f */
+incdir+.
bst_insert_pkg.sv
node_ram.sv
node_alloc.sv
insert_engine.sv
bst_insert_top.sv
bst_insert_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the BST insert testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f bst_insert.f --top-module bst_insert_tb -o bst_insert_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/bst_insert_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0

/* bst_insert_tb.sv */
// ----------------------------------------------------------
// Testbench for bst_insert_top. Needs at least 16 ok inserts
// in the table before the full ones, one request at a time
// ----------------------------------------------------------

`timescale 1ns/1ns

`include "bst_insert_macros.svh"

module bst_insert_tb
    import bst_insert_pkg::*;
;

    localparam int table_len      = 20;
    localparam int timeout_cycles = table_len * 40;

    typedef struct packed {
        token_t      token;
        payload_t    payload;
        cpl_status_e status;
    } stim_entry_t;

    logic        aclk = 1'b0;
    logic        aresetn;
    logic        req_valid;
    logic        req_ready;
    insert_req_t req;
    logic        cpl_valid;
    logic        cpl_ready;
    insert_cpl_t cpl;

    stim_entry_t stim_table [table_len];

    // Reference tree where child index -1 means no child
    token_t      m_token   [`BST_NODE_COUNT];
    payload_t    m_payload [`BST_NODE_COUNT];
    int          m_left    [`BST_NODE_COUNT];
    int          m_right   [`BST_NODE_COUNT];
    int          m_count;

    logic [31:0] lfsr_state = 32'h0f153431;
    int          cycle_count = 0;

    bst_insert_top bst_insert_top_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .cpl_valid (cpl_valid),
        .cpl_ready (cpl_ready),
        .cpl       (cpl)
    );

    always #50 aclk = ~aclk;

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------

    task automatic compare_value(input string what, input logic [63:0] actual,
                                 input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // Right-shifting Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            lfsr_step = (s >> 1) ^ 32'h80200003;
        end else begin
            lfsr_step = s >> 1;
        end
    endfunction

    task automatic set_entry(input int idx, input token_t t, input payload_t p,
                             input cpl_status_e s);
        stim_table[idx].token   = t;
        stim_table[idx].payload = p;
        stim_table[idx].status  = s;
    endtask

    // Entries 7 and 8 repeat earlier tokens
    // The last four hit a full tree
    task automatic load_table();
        set_entry(0,  8'd50,  16'h1000, cpl_ok);
        set_entry(1,  8'd30,  16'h1101, cpl_ok);
        set_entry(2,  8'd70,  16'h1202, cpl_ok);
        set_entry(3,  8'd20,  16'h1303, cpl_ok);
        set_entry(4,  8'd40,  16'h1404, cpl_ok);
        set_entry(5,  8'd60,  16'h1505, cpl_ok);
        set_entry(6,  8'd80,  16'h1606, cpl_ok);
        set_entry(7,  8'd50,  16'h1707, cpl_ok);
        set_entry(8,  8'd30,  16'h1808, cpl_ok);
        set_entry(9,  8'd10,  16'h1909, cpl_ok);
        set_entry(10, 8'd90,  16'h1a0a, cpl_ok);
        set_entry(11, 8'd65,  16'h1b0b, cpl_ok);
        set_entry(12, 8'd75,  16'h1c0c, cpl_ok);
        set_entry(13, 8'd35,  16'h1d0d, cpl_ok);
        set_entry(14, 8'd45,  16'h1e0e, cpl_ok);
        set_entry(15, 8'd55,  16'h1f0f, cpl_ok);
        set_entry(16, 8'd5,   16'h2010, cpl_full);
        set_entry(17, 8'd100, 16'h2111, cpl_full);
        set_entry(18, 8'd50,  16'h2212, cpl_full);
        set_entry(19, 8'd200, 16'h2313, cpl_full);
    endtask

    // ----------------------------------------------------------
    // Reference tree model
    // ----------------------------------------------------------

    // Depth counts the nodes visited and parent is -1 for a root
    task automatic model_walk(input token_t t, output int depth, output int parent);
        int node;
        node   = (m_count == 0) ? -1 : 0;
        depth  = 0;
        parent = -1;
        while (node >= 0) begin
            parent = node;
            depth  = depth + 1;
            if (t <= m_token[node]) begin
                node = m_left[node];
            end else begin
                node = m_right[node];
            end
        end
    endtask

    task automatic model_insert(input token_t t, input payload_t p, input int parent);
        m_token[m_count]   = t;
        m_payload[m_count] = p;
        m_left[m_count]    = -1;
        m_right[m_count]   = -1;
        if (parent >= 0) begin
            if (t <= m_token[parent]) begin
                m_left[parent] = m_count;
            end else begin
                m_right[parent] = m_count;
            end
        end
        m_count = m_count + 1;
    endtask

    task automatic check_completion(input int idx);
        int       depth;
        int       parent;
        token_t   exp_ptoken;
        payload_t exp_ppayload;
        compare_value("status", 64'(cpl.status), 64'(stim_table[idx].status));
        if (stim_table[idx].status == cpl_ok) begin
            model_walk(stim_table[idx].token, depth, parent);
            exp_ptoken   = (parent < 0) ? token_t'(0) : m_token[parent];
            exp_ppayload = (parent < 0) ? payload_t'(0) : m_payload[parent];
            compare_value("node address", 64'(cpl.addr), 64'(m_count));
            compare_value("depth", 64'(cpl.depth), 64'(depth));
            compare_value("parent token", 64'(cpl.parent_token), 64'(exp_ptoken));
            compare_value("parent payload", 64'(cpl.parent_payload), 64'(exp_ppayload));
            model_insert(stim_table[idx].token, stim_table[idx].payload, parent);
        end
    endtask

    // ----------------------------------------------------------
    // Timeout
    // ----------------------------------------------------------

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles with completions still missing", cycle_count);
            $display("Checks failed");
            $fatal(1);
        end
    end

    // ----------------------------------------------------------
    // Stimulus and checks
    // ----------------------------------------------------------

    initial begin
        int          req_idx;
        int          cpl_idx;
        int          outstanding;
        int          loop_cycle;
        logic        req_fire_q;
        logic        cpl_fire;
        logic        held_valid;
        insert_cpl_t held_cpl;

        aresetn     = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        cpl_ready   = 1'b0;
        req_idx     = 0;
        cpl_idx     = 0;
        outstanding = 0;
        loop_cycle  = 0;
        req_fire_q  = 1'b0;
        held_valid  = 1'b0;
        held_cpl    = '0;
        m_count     = 0;
        load_table();

        repeat (5) begin
            @(posedge aclk);
            #10;
            compare_value("req_ready in reset", 64'(req_ready), 64'(0));
            compare_value("cpl_valid in reset", 64'(cpl_valid), 64'(0));
        end
        aresetn   = 1'b1;
        req_valid = 1'b1;
        req       = '{token: stim_table[0].token, payload: stim_table[0].payload};

        while (cpl_idx < table_len) begin
            @(posedge aclk);
            #10;
            if (loop_cycle == 0) begin
                compare_value("cpl_valid after reset", 64'(cpl_valid), 64'(0));
            end
            loop_cycle = loop_cycle + 1;

            // Request accepted at the edge just passed
            if (req_fire_q) begin
                req_idx     = req_idx + 1;
                outstanding = outstanding + 1;
                if (req_idx < table_len) begin
                    req = '{token: stim_table[req_idx].token,
                            payload: stim_table[req_idx].payload};
                end else begin
                    req_valid = 1'b0;
                end
            end
            compare_value("requests in flight", 64'(outstanding > 1), 64'(0));
            compare_value("req_ready while completing", 64'(cpl_valid && req_ready), 64'(0));

            // A completion not taken must hold
            if (held_valid) begin
                compare_value("held cpl_valid", 64'(cpl_valid), 64'(1));
                compare_value("held cpl", 64'(cpl), 64'(held_cpl));
            end

            lfsr_state = lfsr_step(lfsr_state);
            cpl_ready  = lfsr_state[0];

            req_fire_q = req_valid && req_ready;
            cpl_fire   = cpl_valid && cpl_ready;
            held_valid = cpl_valid && !cpl_ready;
            held_cpl   = cpl;

            if (cpl_fire) begin
                compare_value("completion without request", 64'(outstanding), 64'(1));
                check_completion(cpl_idx);
                cpl_idx     = cpl_idx + 1;
                outstanding = outstanding - 1;
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

/* bst_insert_top.sv */
// ----------------------------------------------------------
// BST insert engine with on-chip node memory and allocator
// ----------------------------------------------------------

`timescale 1ns/1ns

module bst_insert_top
    import bst_insert_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        req_valid,
    output logic        req_ready,
    input  insert_req_t req,
    output logic        cpl_valid,
    input  logic        cpl_ready,
    output insert_cpl_t cpl
);

    // Node memory
    logic       rd_en;
    node_addr_t rd_addr;
    node_t      rd_node;
    logic       wr_en;
    node_addr_t wr_addr;
    node_t      wr_node;

    // Allocator
    logic       take;
    node_addr_t next_addr;
    logic       empty;
    logic       full;

    insert_engine insert_engine_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .cpl_valid (cpl_valid),
        .cpl_ready (cpl_ready),
        .cpl       (cpl),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_node   (rd_node),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_node   (wr_node),
        .take      (take),
        .next_addr (next_addr),
        .empty     (empty),
        .full      (full)
    );

    node_alloc node_alloc_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .take      (take),
        .next_addr (next_addr),
        .empty     (empty),
        .full      (full)
    );

    node_ram node_ram_i (
        .aclk    (aclk),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_node (rd_node),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_node (wr_node)
    );

endmodule

/* insert_engine.sv */
// ----------------------------------------------------------
// BST insert walker, one request in flight. The root is
// always at address 0 and equal tokens go to the left
// ----------------------------------------------------------

`timescale 1ns/1ns

module insert_engine
    import bst_insert_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    // Request side
    input  logic        req_valid,
    output logic        req_ready,
    input  insert_req_t req,
    // Completion side
    output logic        cpl_valid,
    input  logic        cpl_ready,
    output insert_cpl_t cpl,
    // Node memory
    output logic        rd_en,
    output node_addr_t  rd_addr,
    input  node_t       rd_node,
    output logic        wr_en,
    output node_addr_t  wr_addr,
    output node_t       wr_node,
    // Allocator
    output logic        take,
    input  node_addr_t  next_addr,
    input  logic        empty,
    input  logic        full
);

    localparam node_addr_t root_addr = '0;

    engine_state_e state;
    engine_state_e state_next;
    logic          req_fire;

    // Latched request and walk context
    insert_req_t   req_q;
    node_addr_t    cur_addr;
    node_addr_t    node_addr_q;
    node_t         parent_node;
    logic          go_right_q;
    depth_t        depth_q;
    cpl_status_e   status_q;

    // Compare results on the node just read
    logic          go_left;
    logic          child_present;
    node_addr_t    child_addr;

    node_t         linked_parent;
    node_t         new_node;

    assign req_fire = req_valid && req_ready;

    assign go_left       = (req_q.token <= rd_node.token);
    assign child_present = go_left ? rd_node.has_left : rd_node.has_right;
    assign child_addr    = go_left ? rd_node.left_addr : rd_node.right_addr;

    // ----------------------------------------------------------
    // FSM
    // ----------------------------------------------------------

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (req_fire) begin
                    if (full) begin
                        state_next = st_complete;
                    end else if (empty) begin
                        state_next = st_write_node;
                    end else begin
                        // Root read is issued on the accept edge
                        state_next = st_compare;
                    end
                end
            end
            st_read:         state_next = st_compare;
            st_compare: begin
                if (child_present) begin
                    state_next = st_read;
                end else begin
                    state_next = st_write_parent;
                end
            end
            st_write_parent: state_next = st_write_node;
            st_write_node:   state_next = st_complete;
            st_complete: begin
                if (cpl_ready) begin
                    state_next = st_idle;
                end
            end
            default:         state_next = st_idle;
        endcase
    end

    // req_ready is low in reset and high only in idle
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= st_idle;
            req_ready <= 1'b0;
        end else begin
            state     <= state_next;
            req_ready <= (state_next == st_idle);
        end
    end

    // ----------------------------------------------------------
    // Walk datapath
    // ----------------------------------------------------------

    always_ff @(posedge aclk) begin
        case (state)
            st_idle: begin
                if (req_fire) begin
                    req_q       <= req;
                    cur_addr    <= root_addr;
                    parent_node <= '0;
                    go_right_q  <= 1'b0;
                    if (full) begin
                        status_q    <= cpl_full;
                        node_addr_q <= '0;
                        depth_q     <= '0;
                    end else begin
                        status_q    <= cpl_ok;
                        node_addr_q <= next_addr;
                        // A non-empty tree puts the new node at least one level down
                        depth_q     <= empty ? depth_t'(0) : depth_t'(1);
                    end
                end
            end
            st_compare: begin
                if (child_present) begin
                    cur_addr <= child_addr;
                    depth_q  <= depth_q + depth_t'(1);
                end else begin
                    // Slot found and cur_addr stays on the parent
                    parent_node <= rd_node;
                    go_right_q  <= !go_left;
                end
            end
            default: begin
            end
        endcase
    end

    // ----------------------------------------------------------
    // Node memory and allocator
    // ----------------------------------------------------------

    assign rd_en   = (req_fire && !full && !empty) || (state == st_read);
    assign rd_addr = (state == st_read) ? cur_addr : root_addr;

    always_comb begin
        linked_parent = parent_node;
        if (go_right_q) begin
            linked_parent.right_addr = node_addr_q;
            linked_parent.has_right  = 1'b1;
        end else begin
            linked_parent.left_addr = node_addr_q;
            linked_parent.has_left  = 1'b1;
        end
    end

    // New leaf whose parent address is 0 for a root
    always_comb begin
        new_node             = '0;
        new_node.payload     = req_q.payload;
        new_node.token       = req_q.token;
        new_node.parent_addr = cur_addr;
    end

    assign wr_en   = (state == st_write_parent) || (state == st_write_node);
    assign wr_addr = (state == st_write_parent) ? cur_addr : node_addr_q;
    assign wr_node = (state == st_write_parent) ? linked_parent : new_node;

    assign take = (state == st_write_node);

    // ----------------------------------------------------------
    // Completion
    // ----------------------------------------------------------

    assign cpl_valid = (state == st_complete);

    assign cpl.status         = status_q;
    assign cpl.addr           = node_addr_q;
    assign cpl.depth          = depth_q;
    assign cpl.parent_token   = parent_node.token;
    assign cpl.parent_payload = parent_node.payload;

endmodule

/* node_alloc.sv */
// ----------------------------------------------------------
// Sequential node allocator. Addresses go out as 0, 1, 2 ...
// and are never freed, so full stays set until reset
// ----------------------------------------------------------

`timescale 1ns/1ns

`include "bst_insert_macros.svh"

module node_alloc
    import bst_insert_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       take,
    output node_addr_t next_addr,
    output logic       empty,
    output logic       full
);

    // One extra bit so the count can reach the node count
    localparam int unsigned count_width = `BST_ADDR_WIDTH + 1;
    localparam logic [count_width-1:0] count_max = count_width'(`BST_NODE_COUNT);

    // Nodes in use
    logic [count_width-1:0] count;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count <= '0;
        end else if (take && !full) begin
            count <= count + count_width'(1);
        end
    end

    // The next free address is the number of nodes in use
    assign next_addr = count[`BST_ADDR_WIDTH-1:0];

    assign empty = (count == '0);
    assign full  = (count == count_max);

endmodule

/* node_ram.sv */
// ----------------------------------------------------------
// Node storage, one write port and one read port. Read data
// is registered and valid the cycle after rd_en
// ----------------------------------------------------------

`timescale 1ns/1ns

`include "bst_insert_macros.svh"

module node_ram
    import bst_insert_pkg::*;
(
    input  logic       aclk,
    // Read port
    input  logic       rd_en,
    input  node_addr_t rd_addr,
    output node_t      rd_node,
    // Write port
    input  logic       wr_en,
    input  node_addr_t wr_addr,
    input  node_t      wr_node
);

    // ----------------------------------------------------------
    // Storage array
    // ----------------------------------------------------------

    // One entry per node address
    node_t mem [`BST_NODE_COUNT];

    // ----------------------------------------------------------
    // Write port
    // ----------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_node;
        end
    end

    // ----------------------------------------------------------
    // Read port
    // ----------------------------------------------------------

    // Output holds the last read until the next rd_en
    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rd_node <= mem[rd_addr];
        end
    end

endmodule

/* bst_insert_pkg.sv */
// ----------------------------------------------------------
// Types shared by the BST insert engine and its memories
// ----------------------------------------------------------

`include "bst_insert_macros.svh"

package bst_insert_pkg;

    // ----------------------------------------------------------
    // Scalar types
    // ----------------------------------------------------------
    typedef logic [`BST_TOKEN_WIDTH-1:0]   token_t;
    typedef logic [`BST_PAYLOAD_WIDTH-1:0] payload_t;
    typedef logic [`BST_ADDR_WIDTH-1:0]    node_addr_t;
    typedef logic [`BST_DEPTH_WIDTH-1:0]   depth_t;

    // One stored tree node
    typedef struct packed {
        payload_t   payload;
        node_addr_t left_addr;
        node_addr_t right_addr;
        node_addr_t parent_addr;
        token_t     token;
        logic       has_left;
        logic       has_right;
    } node_t;

    // ----------------------------------------------------------
    // User request and completion
    // ----------------------------------------------------------
    typedef struct packed {
        token_t   token;
        payload_t payload;
    } insert_req_t;

    typedef enum logic [0:0] {
        cpl_ok   = 1'b0,
        cpl_full = 1'b1
    } cpl_status_e;

    // Parent fields are zero for a root or a rejected insert
    typedef struct packed {
        cpl_status_e status;
        node_addr_t  addr;
        depth_t      depth;
        token_t      parent_token;
        payload_t    parent_payload;
    } insert_cpl_t;

    // Tree walker states
    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_compare,
        st_write_parent,
        st_write_node,
        st_complete
    } engine_state_e;

endpackage

/* bst_insert_macros.svh */
// ----------------------------------------------------------
// Widths and sizes for the BST insert engine. BST_NODE_COUNT
// must equal 2**BST_ADDR_WIDTH and the depth must hold count-1
// ----------------------------------------------------------

`ifndef BST_INSERT_MACROS_SVH
`define BST_INSERT_MACROS_SVH

// ----------------------------------------------------------
// Node contents
// ----------------------------------------------------------

// Sort key of a node
`define BST_TOKEN_WIDTH 8

// User data carried along with the token
`define BST_PAYLOAD_WIDTH 16

// ----------------------------------------------------------
// Tree storage
// ----------------------------------------------------------

// Address of one node in the node memory
`define BST_ADDR_WIDTH 4

// Nodes available at addresses 0 .. count-1
`define BST_NODE_COUNT 16

// Level of a node with the root at level 0
`define BST_DEPTH_WIDTH 4

`endif
